//--- source/decode_pkg.sv
package decode_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 12;
    localparam int BR_OP_W    = 9;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;
    typedef logic [BR_OP_W-1:0]    br_op_t;

    // one-hot bit positions in alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // one-hot bit positions in br_op_t
    localparam int BR_BEQ  = 0;
    localparam int BR_BNE  = 1;
    localparam int BR_BLT  = 2;
    localparam int BR_BGE  = 3;
    localparam int BR_BLTU = 4;
    localparam int BR_BGEU = 5;
    localparam int BR_JIRL = 6;
    localparam int BR_B    = 7;
    localparam int BR_BL   = 8;

    // bits 31:26
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // bits 25:22
    localparam logic [3:0] OP4_3R        = 4'h0;
    localparam logic [3:0] OP4_SHIFT_IMM = 4'h1;
    localparam logic [3:0] OP4_LD_W      = 4'h2;
    localparam logic [3:0] OP4_ST_W      = 4'h6;
    localparam logic [3:0] OP4_SLTI      = 4'h8;
    localparam logic [3:0] OP4_SLTUI     = 4'h9;
    localparam logic [3:0] OP4_ADDI_W    = 4'ha;
    localparam logic [3:0] OP4_ANDI      = 4'hd;
    localparam logic [3:0] OP4_ORI       = 4'he;
    localparam logic [3:0] OP4_XORI      = 4'hf;

    // bits 21:20
    localparam logic [1:0] OP2_SHIFT_IMM = 2'h0;
    localparam logic [1:0] OP2_3R        = 2'h1;

    // bits 19:15
    localparam logic [4:0] OP5_ADD_W  = 5'h00;
    localparam logic [4:0] OP5_SLLI_W = 5'h01;
    localparam logic [4:0] OP5_SUB_W  = 5'h02;
    localparam logic [4:0] OP5_SLT    = 5'h04;
    localparam logic [4:0] OP5_SLTU   = 5'h05;
    localparam logic [4:0] OP5_NOR    = 5'h08;
    localparam logic [4:0] OP5_AND    = 5'h09;
    localparam logic [4:0] OP5_SRLI_W = 5'h09;
    localparam logic [4:0] OP5_OR     = 5'h0a;
    localparam logic [4:0] OP5_XOR    = 5'h0b;
    localparam logic [4:0] OP5_SLL_W  = 5'h0e;
    localparam logic [4:0] OP5_SRL_W  = 5'h0f;
    localparam logic [4:0] OP5_SRA_W  = 5'h10;
    localparam logic [4:0] OP5_SRAI_W = 5'h11;

    localparam reg_addr_t ZERO_REG   = 5'd0;
    localparam reg_addr_t LINK_REG   = 5'd1;
    localparam word_t     RET_OFFSET = 32'd4;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  decode_pkg::word_t     inst,
    output decode_pkg::alu_op_t   alu_op,
    output decode_pkg::br_op_t    br_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output decode_pkg::word_t     imm,
    output decode_pkg::word_t     br_offs,
    output logic                  gr_we,
    output decode_pkg::reg_addr_t dest,
    output logic                  res_from_mem,
    output logic                  mem_store,
    output decode_pkg::reg_addr_t raddr1,
    output decode_pkg::reg_addr_t raddr2,
    output logic                  reads_rj,
    output logic                  reads_rkd
);
    import decode_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic is_3r;
    logic is_shift_imm;
    logic inst_3r;
    logic br_cond;
    logic src2_is_4;
    logic need_ui12;
    logic need_ui20;
    logic src_reg_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    // b and bl split the offset across two fields
    assign i26 = {inst[9:0], inst[25:10]};

    assign is_3r = (op_31_26 == OP6_ALU) && (op_25_22 == OP4_3R) && (op_21_20 == OP2_3R);
    assign is_shift_imm = (op_31_26 == OP6_ALU) && (op_25_22 == OP4_SHIFT_IMM)
                          && (op_21_20 == OP2_SHIFT_IMM);

    always_comb begin
        alu_op = '0;
        alu_op[ALU_ADD] = (is_3r && op_19_15 == OP5_ADD_W)
                          || (op_31_26 == OP6_ALU && op_25_22 == OP4_ADDI_W)
                          || (op_31_26 == OP6_MEM && op_25_22 == OP4_LD_W)
                          || (op_31_26 == OP6_MEM && op_25_22 == OP4_ST_W)
                          || (op_31_26 == OP6_JIRL) || (op_31_26 == OP6_BL)
                          || (op_31_26 == OP6_PCADDU12I && !op_25_22[3]);
        alu_op[ALU_SUB] = is_3r && op_19_15 == OP5_SUB_W;
        alu_op[ALU_SLT] = (is_3r && op_19_15 == OP5_SLT)
                          || (op_31_26 == OP6_ALU && op_25_22 == OP4_SLTI);
        alu_op[ALU_SLTU] = (is_3r && op_19_15 == OP5_SLTU)
                           || (op_31_26 == OP6_ALU && op_25_22 == OP4_SLTUI);
        alu_op[ALU_AND] = (is_3r && op_19_15 == OP5_AND)
                          || (op_31_26 == OP6_ALU && op_25_22 == OP4_ANDI);
        alu_op[ALU_NOR] = is_3r && op_19_15 == OP5_NOR;
        alu_op[ALU_OR] = (is_3r && op_19_15 == OP5_OR)
                         || (op_31_26 == OP6_ALU && op_25_22 == OP4_ORI);
        alu_op[ALU_XOR] = (is_3r && op_19_15 == OP5_XOR)
                          || (op_31_26 == OP6_ALU && op_25_22 == OP4_XORI);
        alu_op[ALU_SLL] = (is_3r && op_19_15 == OP5_SLL_W)
                          || (is_shift_imm && op_19_15 == OP5_SLLI_W);
        alu_op[ALU_SRL] = (is_3r && op_19_15 == OP5_SRL_W)
                          || (is_shift_imm && op_19_15 == OP5_SRLI_W);
        alu_op[ALU_SRA] = (is_3r && op_19_15 == OP5_SRA_W)
                          || (is_shift_imm && op_19_15 == OP5_SRAI_W);
        alu_op[ALU_LUI] = op_31_26 == OP6_LU12I && !op_25_22[3];
    end

    always_comb begin
        br_op = '0;
        br_op[BR_BEQ]  = op_31_26 == OP6_BEQ;
        br_op[BR_BNE]  = op_31_26 == OP6_BNE;
        br_op[BR_BLT]  = op_31_26 == OP6_BLT;
        br_op[BR_BGE]  = op_31_26 == OP6_BGE;
        br_op[BR_BLTU] = op_31_26 == OP6_BLTU;
        br_op[BR_BGEU] = op_31_26 == OP6_BGEU;
        br_op[BR_JIRL] = op_31_26 == OP6_JIRL;
        br_op[BR_B]    = op_31_26 == OP6_B;
        br_op[BR_BL]   = op_31_26 == OP6_BL;
    end

    // register-register forms among the recognised ones
    assign inst_3r = is_3r && (|alu_op);
    assign br_cond = |br_op[BR_BGEU:BR_BEQ];

    assign mem_store    = (op_31_26 == OP6_MEM) && (op_25_22 == OP4_ST_W);
    assign res_from_mem = (op_31_26 == OP6_MEM) && (op_25_22 == OP4_LD_W);

    assign src2_is_4 = br_op[BR_JIRL] | br_op[BR_BL];
    assign need_ui12 = (op_31_26 == OP6_ALU)
                       && (op_25_22 == OP4_ANDI || op_25_22 == OP4_ORI
                           || op_25_22 == OP4_XORI);
    assign need_ui20 = alu_op[ALU_LUI]
                       | (op_31_26 == OP6_PCADDU12I && !op_25_22[3]);

    assign imm = src2_is_4 ? RET_OFFSET :
                 need_ui20 ? {i20, 12'b0} :
                 need_ui12 ? {20'b0, i12} :
                             {{20{i12[11]}}, i12};

    assign br_offs = (br_op[BR_B] | br_op[BR_BL]) ? {{4{i26[25]}}, i26, 2'b0} :
                                                    {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc  = br_op[BR_JIRL] | br_op[BR_BL] | (need_ui20 & ~alu_op[ALU_LUI]);
    assign src2_is_imm = (|alu_op) & ~inst_3r;

    // every alu user writes back, except the store
    assign gr_we = (|alu_op) & ~mem_store;
    assign dest  = br_op[BR_BL] ? LINK_REG : rd;

    assign src_reg_is_rd = br_cond | mem_store;
    assign raddr1 = rj;
    assign raddr2 = src_reg_is_rd ? rd : rk;

    assign reads_rj  = ((|alu_op) & ~need_ui20 & ~br_op[BR_BL]) | br_cond;
    assign reads_rkd = inst_3r | mem_store | br_cond;

    onehot_ops: assert final ($onehot0(alu_op) && $onehot0(br_op));

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  logic                  we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);
    import decode_pkg::*;

    word_t regs [NUM_REGS];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != ZERO_REG) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == ZERO_REG) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == ZERO_REG) ? '0 : regs[raddr2];

    // same-edge writes are covered by forwarding, not here
    write_then_read: assert property (
        @(posedge clk) (we && waddr != ZERO_REG)
            |=> (raddr1 != $past(waddr) || rdata1 == $past(wdata))
    );

endmodule

//--- source/operand_forward.sv
`timescale 1ns/10ps

module operand_forward (
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  logic                  reads_rj,
    input  logic                  reads_rkd,
    input  decode_pkg::word_t     rdata1,
    input  decode_pkg::word_t     rdata2,
    input  logic                  es_valid,
    input  logic                  es_we,
    input  logic                  es_res_from_mem,
    input  decode_pkg::reg_addr_t es_dest,
    input  decode_pkg::word_t     es_result,
    input  logic                  ms_valid,
    input  logic                  ms_we,
    input  decode_pkg::reg_addr_t ms_dest,
    input  decode_pkg::word_t     ms_result,
    input  logic                  rf_we,
    input  decode_pkg::reg_addr_t rf_waddr,
    input  decode_pkg::word_t     rf_wdata,
    output decode_pkg::word_t     rj_value,
    output decode_pkg::word_t     rkd_value,
    output logic                  load_stall
);
    import decode_pkg::*;

    logic es_fwd_ok;
    logic es_load;
    logic ms_fwd_ok;

    // youngest producer wins
    function automatic word_t fwd_value(input reg_addr_t raddr, input word_t rdata);
        if (raddr == ZERO_REG) begin
            return '0;
        end else if (es_fwd_ok && raddr == es_dest) begin
            return es_result;
        end else if (ms_fwd_ok && raddr == ms_dest) begin
            return ms_result;
        end else if (rf_we && raddr == rf_waddr) begin
            return rf_wdata;
        end
        return rdata;
    endfunction

    function automatic logic load_hit(input logic reads, input reg_addr_t raddr);
        return reads && (raddr != ZERO_REG) && (raddr == es_dest);
    endfunction

    assign es_fwd_ok = es_valid && es_we && !es_res_from_mem;
    assign es_load   = es_valid && es_we && es_res_from_mem;
    assign ms_fwd_ok = ms_valid && ms_we;

    assign rj_value  = fwd_value(raddr1, rdata1);
    assign rkd_value = fwd_value(raddr2, rdata2);

    // load data only exists after memory, so wait one cycle
    assign load_stall = es_load && (load_hit(reads_rj, raddr1) || load_hit(reads_rkd, raddr2));

    stall_needs_es: assert final (es_valid || !load_stall);

endmodule

//--- source/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  decode_pkg::br_op_t br_op,
    input  decode_pkg::word_t  pc,
    input  decode_pkg::word_t  br_offs,
    input  decode_pkg::word_t  rj_value,
    input  decode_pkg::word_t  rkd_value,
    output logic               cond_true,
    output decode_pkg::word_t  target
);
    import decode_pkg::*;

    logic  equal;
    logic  less_s;
    logic  less_u;
    word_t base;

    assign equal  = rj_value == rkd_value;
    assign less_s = $signed(rj_value) < $signed(rkd_value);
    assign less_u = rj_value < rkd_value;

    always_comb begin
        cond_true = 1'b0;
        if (br_op[BR_BEQ] && equal) begin
            cond_true = 1'b1;
        end
        if (br_op[BR_BNE] && !equal) begin
            cond_true = 1'b1;
        end
        if ((br_op[BR_BLT] && less_s) || (br_op[BR_BGE] && !less_s)) begin
            cond_true = 1'b1;
        end
        if ((br_op[BR_BLTU] && less_u) || (br_op[BR_BGEU] && !less_u)) begin
            cond_true = 1'b1;
        end
        // unconditional jumps
        if (br_op[BR_JIRL] || br_op[BR_B] || br_op[BR_BL]) begin
            cond_true = 1'b1;
        end
    end

    // jirl is register relative, everything else pc relative
    assign base   = br_op[BR_JIRL] ? rj_value : pc;
    assign target = base + br_offs;

endmodule

//--- source/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::word_t     fs_pc,
    input  decode_pkg::word_t     fs_inst,
    input  logic                  es_allowin,
    input  logic                  es_valid,
    input  logic                  es_we,
    input  logic                  es_res_from_mem,
    input  decode_pkg::reg_addr_t es_dest,
    input  decode_pkg::word_t     es_result,
    input  logic                  ms_valid,
    input  logic                  ms_we,
    input  decode_pkg::reg_addr_t ms_dest,
    input  decode_pkg::word_t     ms_result,
    input  logic                  rf_we,
    input  decode_pkg::reg_addr_t rf_waddr,
    input  decode_pkg::word_t     rf_wdata,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::word_t     ds_pc,
    output decode_pkg::alu_op_t   alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output decode_pkg::word_t     imm,
    output decode_pkg::word_t     rj_value,
    output decode_pkg::word_t     rkd_value,
    output logic                  gr_we,
    output decode_pkg::reg_addr_t dest,
    output logic                  res_from_mem,
    output logic                  mem_store,
    output logic                  br_taken,
    output decode_pkg::word_t     br_target
);
    import decode_pkg::*;

    logic      ds_valid;
    word_t     ds_inst;
    logic      ds_ready_go;
    br_op_t    br_op;
    word_t     br_offs;
    logic      dec_gr_we;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      reads_rj;
    logic      reads_rkd;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      load_stall;
    logic      cond_true;

    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;
    assign br_taken       = ds_valid && ds_ready_go && cond_true;
    // a bubble never writes back
    assign gr_we          = ds_valid && dec_gr_we;

    // taken branch kills the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    inst_decoder inst_decoder_inst (
        .inst         (ds_inst),
        .alu_op       (alu_op),
        .br_op        (br_op),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .imm          (imm),
        .br_offs      (br_offs),
        .gr_we        (dec_gr_we),
        .dest         (dest),
        .res_from_mem (res_from_mem),
        .mem_store    (mem_store),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .reads_rj     (reads_rj),
        .reads_rkd    (reads_rkd)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_forward operand_forward_inst (
        .raddr1          (raddr1),
        .raddr2          (raddr2),
        .reads_rj        (reads_rj),
        .reads_rkd       (reads_rkd),
        .rdata1          (rf_rdata1),
        .rdata2          (rf_rdata2),
        .es_valid        (es_valid),
        .es_we           (es_we),
        .es_res_from_mem (es_res_from_mem),
        .es_dest         (es_dest),
        .es_result       (es_result),
        .ms_valid        (ms_valid),
        .ms_we           (ms_we),
        .ms_dest         (ms_dest),
        .ms_result       (ms_result),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .load_stall      (load_stall)
    );

    branch_unit branch_unit_inst (
        .br_op     (br_op),
        .pc        (ds_pc),
        .br_offs   (br_offs),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .cond_true (cond_true),
        .target    (br_target)
    );

    empty_stage_quiet: assert property (
        @(posedge clk) disable iff (reset) !ds_valid |-> !ds_to_es_valid && !br_taken
    );

    taken_branch_empties: assert property (
        @(posedge clk) disable iff (reset) br_taken |=> !ds_valid
    );

endmodule

//--- tests/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// model state, lives inside decode_stage_tb
word_t     ref_regs [32];
logic      m_valid;
word_t     m_pc;
word_t     m_inst;
alu_op_t   m_alu;
br_op_t    m_br;
logic      m_s1pc;
logic      m_s2imm;
word_t     m_imm;
word_t     m_offs;
logic      m_we;
reg_addr_t m_dest;
logic      m_load;
logic      m_store;
logic      m_rj_used;
logic      m_rkd_used;
reg_addr_t m_rkd_addr;

word_t     exp_rj;
word_t     exp_rkd;
word_t     exp_target;
logic      exp_stall;
logic      exp_out_valid;
logic      exp_allowin;
logic      exp_taken;

// rj plus 12 bit immediate, written back to rd
function automatic void imm_op(input int bit_pos, input logic zext, input word_t inst);
    m_alu[bit_pos] = 1'b1;
    m_s2imm = 1'b1;
    m_we = 1'b1;
    m_rj_used = 1'b1;
    m_imm = zext ? {20'b0, inst[21:10]} : {{20{inst[21]}}, inst[21:10]};
endfunction

function automatic void decode_ref(input word_t inst);
    m_alu = '0;
    m_br = '0;
    m_s1pc = 1'b0;
    m_s2imm = 1'b0;
    m_imm = '0;
    m_we = 1'b0;
    m_dest = inst[4:0];
    m_load = 1'b0;
    m_store = 1'b0;
    m_rj_used = 1'b0;
    m_rkd_used = 1'b0;
    m_rkd_addr = inst[14:10];
    m_offs = {{14{inst[25]}}, inst[25:10], 2'b00};
    if (inst[31:20] == 12'h001) begin
        m_rj_used = 1'b1;
        m_rkd_used = 1'b1;
        m_we = 1'b1;
        case (inst[19:15])
            5'h00: m_alu[ALU_ADD] = 1'b1;
            5'h02: m_alu[ALU_SUB] = 1'b1;
            5'h04: m_alu[ALU_SLT] = 1'b1;
            5'h05: m_alu[ALU_SLTU] = 1'b1;
            5'h08: m_alu[ALU_NOR] = 1'b1;
            5'h09: m_alu[ALU_AND] = 1'b1;
            5'h0a: m_alu[ALU_OR] = 1'b1;
            5'h0b: m_alu[ALU_XOR] = 1'b1;
            5'h0e: m_alu[ALU_SLL] = 1'b1;
            5'h0f: m_alu[ALU_SRL] = 1'b1;
            5'h10: m_alu[ALU_SRA] = 1'b1;
            default: begin
                m_rj_used = 1'b0;
                m_rkd_used = 1'b0;
                m_we = 1'b0;
            end
        endcase
    end else if (inst[31:20] == 12'h004) begin
        case (inst[19:15])
            5'h01: imm_op(ALU_SLL, 1'b0, inst);
            5'h09: imm_op(ALU_SRL, 1'b0, inst);
            5'h11: imm_op(ALU_SRA, 1'b0, inst);
            default: ;
        endcase
    end else if (inst[31:26] == 6'h00) begin
        case (inst[25:22])
            4'h8: imm_op(ALU_SLT, 1'b0, inst);
            4'h9: imm_op(ALU_SLTU, 1'b0, inst);
            4'ha: imm_op(ALU_ADD, 1'b0, inst);
            4'hd: imm_op(ALU_AND, 1'b1, inst);
            4'he: imm_op(ALU_OR, 1'b1, inst);
            4'hf: imm_op(ALU_XOR, 1'b1, inst);
            default: ;
        endcase
    end else if (inst[31:25] == 7'h0a || inst[31:25] == 7'h0e) begin
        // lu12i.w, or pcaddu12i when pc relative
        m_s1pc = inst[31:25] == 7'h0e;
        m_alu[m_s1pc ? ALU_ADD : ALU_LUI] = 1'b1;
        m_s2imm = 1'b1;
        m_we = 1'b1;
        m_imm = {inst[24:5], 12'b0};
    end else if (inst[31:26] == 6'h0a && inst[25:22] == 4'h2) begin
        imm_op(ALU_ADD, 1'b0, inst);
        m_load = 1'b1;
    end else if (inst[31:26] == 6'h0a && inst[25:22] == 4'h6) begin
        imm_op(ALU_ADD, 1'b0, inst);
        m_we = 1'b0;
        m_store = 1'b1;
        m_rkd_used = 1'b1;
        m_rkd_addr = inst[4:0];
    end else if (inst[31:26] == 6'h13) begin
        imm_op(ALU_ADD, 1'b0, inst);
        m_br[BR_JIRL] = 1'b1;
        m_s1pc = 1'b1;
        m_imm = 32'd4;
    end else if (inst[31:26] == 6'h14 || inst[31:26] == 6'h15) begin
        m_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        if (inst[26]) begin
            m_br[BR_BL] = 1'b1;
            m_alu[ALU_ADD] = 1'b1;
            m_s1pc = 1'b1;
            m_s2imm = 1'b1;
            m_imm = 32'd4;
            m_we = 1'b1;
            m_dest = 5'd1;
        end else begin
            m_br[BR_B] = 1'b1;
        end
    end else if (inst[31:26] >= 6'h16 && inst[31:26] <= 6'h1b) begin
        m_br[BR_BEQ + (inst[31:26] - 6'h16)] = 1'b1;
        m_rj_used = 1'b1;
        m_rkd_used = 1'b1;
        m_rkd_addr = inst[4:0];
    end
endfunction

// youngest stage first, then the writeback port, then the array
function automatic word_t fwd_ref(input reg_addr_t a);
    if (a == 5'd0) begin
        return '0;
    end
    if (es_valid && es_we && !es_res_from_mem && es_dest == a) begin
        return es_result;
    end
    if (ms_valid && ms_we && ms_dest == a) begin
        return ms_result;
    end
    if (rf_we && rf_waddr == a) begin
        return rf_wdata;
    end
    return ref_regs[a];
endfunction

function automatic void compute_expected();
    logic es_load;
    logic eq;
    logic lt;
    logic ltu;
    logic cond;
    decode_ref(m_inst);
    exp_rj = fwd_ref(m_inst[9:5]);
    exp_rkd = fwd_ref(m_rkd_addr);
    es_load = es_valid && es_we && es_res_from_mem;
    exp_stall = es_load && ((m_rj_used && m_inst[9:5] != 5'd0 && m_inst[9:5] == es_dest)
                || (m_rkd_used && m_rkd_addr != 5'd0 && m_rkd_addr == es_dest));
    exp_out_valid = m_valid && !exp_stall;
    exp_allowin = !m_valid || (!exp_stall && es_allowin);
    eq = exp_rj == exp_rkd;
    lt = $signed(exp_rj) < $signed(exp_rkd);
    ltu = exp_rj < exp_rkd;
    cond = (m_br[BR_BEQ] && eq) || (m_br[BR_BNE] && !eq)
           || (m_br[BR_BLT] && lt) || (m_br[BR_BGE] && !lt)
           || (m_br[BR_BLTU] && ltu) || (m_br[BR_BGEU] && !ltu)
           || m_br[BR_JIRL] || m_br[BR_B] || m_br[BR_BL];
    exp_taken = exp_out_valid && cond;
    exp_target = (m_br[BR_JIRL] ? exp_rj : m_pc) + m_offs;
endfunction

// one clock edge, with the inputs of the cycle that just ended
function automatic void step_model();
    if (rf_we && rf_waddr != 5'd0) begin
        ref_regs[rf_waddr] = rf_wdata;
    end
    if (exp_out_valid && es_allowin) begin
        retired++;
    end
    if (fs_to_ds_valid && exp_allowin) begin
        m_pc = fs_pc;
        m_inst = fs_inst;
    end
    if (exp_taken) begin
        m_valid = 1'b0;
    end else if (exp_allowin) begin
        m_valid = fs_to_ds_valid;
    end
endfunction

`endif

//--- tests/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;
    import decode_pkg::*;

    localparam int NUM_INSTS   = 3000;
    localparam int CYCLE_LIMIT = NUM_INSTS * 6 + 2000;

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    word_t     fs_pc;
    word_t     fs_inst;
    logic      es_allowin;
    logic      es_valid;
    logic      es_we;
    logic      es_res_from_mem;
    reg_addr_t es_dest;
    word_t     es_result;
    logic      ms_valid;
    logic      ms_we;
    reg_addr_t ms_dest;
    word_t     ms_result;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      ds_allowin;
    logic      ds_to_es_valid;
    word_t     ds_pc;
    alu_op_t   alu_op;
    logic      src1_is_pc;
    logic      src2_is_imm;
    word_t     imm;
    word_t     rj_value;
    word_t     rkd_value;
    logic      gr_we;
    reg_addr_t dest;
    logic      res_from_mem;
    logic      mem_store;
    logic      br_taken;
    word_t     br_target;

    logic [31:0] rng_state = 32'hae31_1b29;
    int          cycles = 0;
    int          retired = 0;

    `include "decode_ref_model.svh"

    decode_stage decode_stage_inst (.*);

    always #10 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            report_failure("Timeout: the instruction stream did not drain within the cycle limit");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            report_failure($sformatf("Fail at %0t: %s is %h, expected %h",
                                     $time, name, got, want));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            report_failure($sformatf("Fail at %0t: %s is %0d, expected %0d",
                                     $time, name, got, want));
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t want);
        if (got !== want) begin
            report_failure($sformatf("Fail at %0t: %s is %b, expected %b",
                                     $time, name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            report_failure($sformatf("Fail at %0t: %s is %b, expected %b",
                                     $time, name, got, want));
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // mostly r0..r3 so that hazards and forwarding hits are common
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = next_random();
        return (r[4:2] == 3'd0) ? r[12:8] : {3'b000, r[1:0]};
    endfunction

    function automatic word_t random_inst();
        logic [31:0] r;
        logic [31:0] f;
        logic [4:0]  op5;
        logic [4:0]  shift_op;
        logic [5:0]  br_op6;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        r = next_random();
        f = next_random();
        rd = pick_reg();
        rj = pick_reg();
        rk = pick_reg();
        op5 = r[31:8] % 17;
        shift_op = (f[6:5] == 2'd0) ? 5'h01 : (f[6:5] == 2'd1) ? 5'h09 : 5'h11;
        br_op6 = 6'h16 + r[31:8] % 6;
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: return {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
            4'd4: return {6'h00, 4'h1, 2'h0, shift_op, f[4:0], rj, rd};
            4'd5, 4'd6: return {6'h00, 1'b1, r[6:4], f[11:0], rj, rd};
            4'd7: return {4'b0001, r[4], 2'b10, f[19:0], rd};
            4'd8: return {6'h0a, 4'h2, f[11:0], rj, rd};
            4'd9: return {6'h0a, 4'h6, f[11:0], rj, rd};
            4'd10: return {6'h13, f[15:0], rj, rd};
            4'd11: return {5'b01010, r[4], f[25:0]};
            4'd12, 4'd13: return {br_op6, f[15:0], rj, rd};
            default: return f;
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        r = next_random();
        fs_to_ds_valid = r[1:0] != 2'b00;
        fs_pc = next_random() & 32'hffff_fffc;
        fs_inst = random_inst();
        es_allowin = r[3:2] != 2'b00;
        es_valid = r[5:4] != 2'b00;
        es_we = r[7:6] != 2'b00;
        es_res_from_mem = r[9:8] == 2'b00;
        es_dest = pick_reg();
        es_result = next_random();
        ms_valid = r[11:10] != 2'b00;
        ms_we = r[13:12] != 2'b00;
        ms_dest = pick_reg();
        ms_result = next_random();
        rf_we = r[15:14] != 2'b00;
        rf_waddr = pick_reg();
        rf_wdata = next_random();
    endtask

    // write one register while the stage passes all-zero words through
    task automatic fill_cycle(input reg_addr_t r);
        fs_to_ds_valid = 1'b1;
        fs_pc = {r, 2'b00};
        fs_inst = '0;
        es_allowin = 1'b1;
        es_valid = 1'b0;
        ms_valid = 1'b0;
        rf_we = 1'b1;
        rf_waddr = r;
        rf_wdata = next_random();
    endtask

    task automatic check_outputs();
        compute_expected();
        check_bit("ds_allowin", ds_allowin, exp_allowin);
        check_bit("ds_to_es_valid", ds_to_es_valid, exp_out_valid);
        check_bit("br_taken", br_taken, exp_taken);
        check_bit("gr_we", gr_we, m_valid && m_we);
        if (m_valid) begin
            check_word("ds_pc", ds_pc, m_pc);
            check_alu_op("alu_op", alu_op, m_alu);
            check_bit("src1_is_pc", src1_is_pc, m_s1pc);
            check_bit("src2_is_imm", src2_is_imm, m_s2imm);
            check_bit("res_from_mem", res_from_mem, m_load);
            check_bit("mem_store", mem_store, m_store);
            check_word("rj_value", rj_value, exp_rj);
            check_word("rkd_value", rkd_value, exp_rkd);
            if (m_s2imm) begin
                check_word("imm", imm, m_imm);
            end
            if (m_we) begin
                check_addr("dest", dest, m_dest);
            end
            if (exp_taken) begin
                check_word("br_target", br_target, exp_target);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_pc = '0;
        fs_inst = '0;
        es_allowin = 1'b0;
        es_valid = 1'b0;
        es_we = 1'b0;
        es_res_from_mem = 1'b0;
        es_dest = '0;
        es_result = '0;
        ms_valid = 1'b0;
        ms_we = 1'b0;
        ms_dest = '0;
        ms_result = '0;
        rf_we = 1'b0;
        rf_waddr = '0;
        rf_wdata = '0;
        m_valid = 1'b0;
        exp_out_valid = 1'b0;
        exp_allowin = 1'b1;
        exp_taken = 1'b0;

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        // empty stage right after reset
        @(negedge clk);
        check_outputs();

        for (int r = 1; r < NUM_REGS; r++) begin
            @(posedge clk);
            step_model();
            #2;
            fill_cycle(reg_addr_t'(r));
            @(negedge clk);
            check_outputs();
        end

        retired = 0;
        while (retired < NUM_INSTS) begin
            @(posedge clk);
            step_model();
            #2;
            drive_random();
            @(negedge clk);
            check_outputs();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- sim.f
+incdir+tests
source/decode_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_forward.sv
source/branch_unit.sv
source/decode_stage.sv
tests/decode_stage_tb.sv
